//--- verilog/fractalPkg.sv
/*
  Shared fixed-point types and constants for the Mandelbrot pipeline.
  Coordinates are signed 4.32 fixed point, so values stay within (-8, 8).
  Screen size and iteration limit are fixed here, not per module.
*/
package fractalPkg;

  typedef logic signed [35:0] coordT;   // 4 integer bits, 32 fraction bits

  // One coordinate word, used as a number or split into its fields
  typedef union packed {
    coordT raw;
    struct packed {
      logic signed [3:0] intPart;       // Escape test looks here only
      logic [31:0]       fracPart;
    } parts;
  } coordWordU;

  localparam int SCREEN_W = 640;
  localparam int SCREEN_H = 480;

  typedef logic [9:0] vgaXT;
  typedef logic [8:0] vgaYT;
  typedef logic [4:0] zoomT;

  localparam int MAX_ITER = 64;
  typedef logic [6:0] iterT;            // Holds 0 to MAX_ITER

  // Zoom 0 steps, 3/640 across and 2/480 down
  localparam coordT X_STEP = 36'sh001333333;
  localparam coordT Y_STEP = 36'sh001111111;

  typedef logic [7:0] colorT;

  localparam int ESCAPE_INT = 4;        // Escape once |z|^2 reaches 4

endpackage

//--- verilog/fractalIfs.sv
/*
  Handshake buses between pipeline stages.
  A word moves on a clock edge with valid and ready both high.
  Data stays put while valid is high and ready is low.
*/
`timescale 1ns/100ps

interface pointIf;
  logic              valid;
  logic              ready;
  fractalPkg::vgaXT  vgaX;
  fractalPkg::vgaYT  vgaY;
  fractalPkg::coordT coordX;   // Real part of c
  fractalPkg::coordT coordY;   // Imaginary part of c

  modport source (output valid, vgaX, vgaY, coordX, coordY, input ready);
  modport sink   (input valid, vgaX, vgaY, coordX, coordY, output ready);
endinterface

interface escapeIf;
  logic             valid;
  logic             ready;
  fractalPkg::vgaXT vgaX;
  fractalPkg::vgaYT vgaY;
  fractalPkg::iterT iterCount;  // Iterations before escape or limit

  modport source (output valid, vgaX, vgaY, iterCount, input ready);
  modport sink   (input valid, vgaX, vgaY, iterCount, output ready);
endinterface

//--- verilog/coordGenerator.sv
/*
  Walks the screen in raster order and emits one complex point per pixel.
  Corner, zoom and steps are sampled on draw; later input changes wait
  for the next draw. After pixel (639, 479) it idles until draw.
*/
`timescale 1ns/100ps

module coordGenerator (
  input  logic              clk,
  input  logic              rstN,
  input  logic              draw,
  input  fractalPkg::zoomT  zoomLevel,
  input  fractalPkg::coordT upperLeftX,
  input  fractalPkg::coordT upperLeftY,
  pointIf.source            pointOut
);

  logic              startPending;   // One cycle between draw and first point
  fractalPkg::coordT cornerX;        // Row start for coordX
  fractalPkg::coordT xStep;
  fractalPkg::coordT yStep;

  logic xfer;
  logic rowEnd;
  logic lastPoint;

  assign xfer      = pointOut.valid && pointOut.ready;
  assign rowEnd    = pointOut.vgaX == fractalPkg::vgaXT'(fractalPkg::SCREEN_W - 1);
  assign lastPoint = rowEnd &&
                     (pointOut.vgaY == fractalPkg::vgaYT'(fractalPkg::SCREEN_H - 1));

  // Control: start, run, stop after the last pixel
  always_ff @(posedge clk) begin
    if (!rstN) begin
      startPending   <= 1'b0;
      pointOut.valid <= 1'b0;
    end else if (draw) begin
      startPending   <= 1'b1;
      pointOut.valid <= 1'b0;
    end else if (startPending) begin
      startPending   <= 1'b0;
      pointOut.valid <= 1'b1;            // First point, (0, 0)
    end else if (xfer && lastPoint) begin
      pointOut.valid <= 1'b0;            // Frame walked, idle
    end
  end

  // Position and coordinate registers
  always_ff @(posedge clk) begin
    if (draw) begin
      cornerX         <= upperLeftX;
      xStep           <= fractalPkg::X_STEP >>> zoomLevel;  // Halves per zoom level
      yStep           <= fractalPkg::Y_STEP >>> zoomLevel;
      pointOut.vgaX   <= '0;
      pointOut.vgaY   <= '0;
      pointOut.coordX <= upperLeftX;
      pointOut.coordY <= upperLeftY;
    end else if (xfer && !lastPoint) begin
      if (rowEnd) begin
        pointOut.vgaX   <= '0;           // Wrap to next row
        pointOut.vgaY   <= pointOut.vgaY + 1'b1;
        pointOut.coordX <= cornerX;
        pointOut.coordY <= pointOut.coordY + yStep;
      end else begin
        pointOut.vgaX   <= pointOut.vgaX + 1'b1;
        pointOut.coordX <= pointOut.coordX + xStep;
      end
    end
  end

  // A point on offer stays unchanged until taken, unless draw restarts the frame
  holdUntilReady: assert property (
    @(posedge clk) disable iff (!rstN)
    pointOut.valid && !pointOut.ready && !draw
      |=> pointOut.valid && $stable(pointOut.vgaX) && $stable(pointOut.vgaY) &&
          $stable(pointOut.coordX) && $stable(pointOut.coordY)
  );

endmodule

//--- verilog/escapeEngine.sv
/*
  Escape-time iteration of z <- z^2 + c, one point at a time.
  Takes a point only when idle and holds its result until taken.
  Latency is iterCount+1 cycles; squares use full 72-bit products.
*/
`timescale 1ns/100ps

module escapeEngine (
  input  logic clk,
  input  logic rstN,
  input  logic draw,
  pointIf.sink    pointIn,
  escapeIf.source resultOut
);

  logic armed;        // Set by the first draw
  logic busy;         // Iterating
  logic resultValid;

  fractalPkg::coordT cr;
  fractalPkg::coordT ci;
  fractalPkg::coordT zr;
  fractalPkg::coordT zi;
  fractalPkg::vgaXT  posX;
  fractalPkg::vgaYT  posY;
  fractalPkg::iterT  count;

  logic signed [71:0] zrSqFull;    // 8.64 products
  logic signed [71:0] ziSqFull;
  logic signed [71:0] crossFull;
  fractalPkg::coordT  zrSq;
  fractalPkg::coordT  ziSq;
  fractalPkg::coordT  zrNext;
  fractalPkg::coordT  ziNext;
  fractalPkg::coordWordU sumWord;  // |z|^2
  logic sqOverflow;
  logic escaped;
  logic stopNow;
  logic accept;

  assign zrSqFull  = zr * zr;
  assign ziSqFull  = zi * zi;
  assign crossFull = zr * zi;

  // Back to 4.32; squares are never negative
  assign zrSq       = zrSqFull[67:32];
  assign ziSq       = ziSqFull[67:32];
  assign sqOverflow = (|zrSqFull[71:67]) || (|ziSqFull[71:67]);

  assign sumWord.raw = zrSq + ziSq;
  assign escaped     = sqOverflow ||
                       (sumWord.parts.intPart < 0) ||   // Sum wrapped past 8
                       (sumWord.parts.intPart >= fractalPkg::ESCAPE_INT);
  assign stopNow     = escaped || (count == fractalPkg::iterT'(fractalPkg::MAX_ITER));

  assign zrNext = zrSq - ziSq + cr;
  assign ziNext = crossFull[66:31] + ci;                // 2*zr*zi

  assign pointIn.ready = armed && !busy && !resultValid;
  assign accept        = pointIn.valid && pointIn.ready;

  assign resultOut.valid     = resultValid;
  assign resultOut.vgaX      = posX;
  assign resultOut.vgaY      = posY;
  assign resultOut.iterCount = count;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      armed       <= 1'b0;
      busy        <= 1'b0;
      resultValid <= 1'b0;
    end else if (draw) begin
      armed       <= 1'b1;
      busy        <= 1'b0;            // Drop any point in flight
      resultValid <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if (busy && stopNow) begin
      busy        <= 1'b0;
      resultValid <= 1'b1;
    end else if (resultValid && resultOut.ready) begin
      resultValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cr    <= pointIn.coordX;
      ci    <= pointIn.coordY;
      posX  <= pointIn.vgaX;
      posY  <= pointIn.vgaY;
      zr    <= '0;
      zi    <= '0;
      count <= '0;
    end else if (busy && !stopNow) begin
      zr    <= zrNext;
      zi    <= ziNext;
      count <= count + 1'b1;
    end
  end

  countInRange: assert property (
    @(posedge clk) disable iff (!rstN)
    resultOut.valid |-> resultOut.iterCount <= fractalPkg::iterT'(fractalPkg::MAX_ITER)
  );

endmodule

//--- verilog/colorMapper.sv
/*
  Maps iteration counts to 8-bit colors in a one-entry output register.
  Count MAX_ITER gives black; others give {count[5:0], 2'b11}.
  frameDone rises when pixel (639, 479) leaves and clears on draw.
*/
`timescale 1ns/100ps

module colorMapper (
  input  logic              clk,
  input  logic              rstN,
  input  logic              draw,
  input  logic              pixelReady,
  escapeIf.sink             resultIn,
  output logic              pixelValid,
  output fractalPkg::vgaXT  pixelX,
  output fractalPkg::vgaYT  pixelY,
  output fractalPkg::colorT pixelColor,
  output logic              frameDone
);

  logic armed;
  logic accept;
  logic pixelOut;
  logic lastPixel;

  assign resultIn.ready = armed && (!pixelValid || pixelReady);  // Empty or emptying
  assign accept         = resultIn.valid && resultIn.ready;
  assign pixelOut       = pixelValid && pixelReady;
  assign lastPixel      = (pixelX == fractalPkg::vgaXT'(fractalPkg::SCREEN_W - 1)) &&
                          (pixelY == fractalPkg::vgaYT'(fractalPkg::SCREEN_H - 1));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      armed      <= 1'b0;
      pixelValid <= 1'b0;
      frameDone  <= 1'b0;
    end else if (draw) begin
      armed      <= 1'b1;
      pixelValid <= 1'b0;
      frameDone  <= 1'b0;
    end else begin
      if (accept)        pixelValid <= 1'b1;
      else if (pixelOut) pixelValid <= 1'b0;
      if (pixelOut && lastPixel) frameDone <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pixelX <= resultIn.vgaX;
      pixelY <= resultIn.vgaY;
      if (resultIn.iterCount == fractalPkg::iterT'(fractalPkg::MAX_ITER))
        pixelColor <= '0;                                  // Inside the set
      else
        pixelColor <= {resultIn.iterCount[5:0], 2'b11};
    end
  end

  noPixelInReset: assert property (@(posedge clk) !rstN |=> !pixelValid);

endmodule

//--- verilog/fractalTop.sv
/*
  Mandelbrot pipeline: coordinate walk, escape iteration, color mapping.
  Nothing runs until the first draw; draw restarts the frame at any time.
  Pixels leave on pixelValid and pixelReady both high.
*/
`timescale 1ns/100ps

module fractalTop (
  input  logic              clk,
  input  logic              rstN,
  input  logic              draw,
  input  fractalPkg::zoomT  zoomLevel,
  input  fractalPkg::coordT upperLeftX,
  input  fractalPkg::coordT upperLeftY,
  input  logic              pixelReady,
  output logic              pixelValid,
  output fractalPkg::vgaXT  pixelX,
  output fractalPkg::vgaYT  pixelY,
  output fractalPkg::colorT pixelColor,
  output logic              frameDone
);

  pointIf  pointBus ();   // Generator to engine
  escapeIf escapeBus ();  // Engine to color stage

  coordGenerator i_coordGenerator (
    .clk        (clk),
    .rstN       (rstN),
    .draw       (draw),
    .zoomLevel  (zoomLevel),
    .upperLeftX (upperLeftX),
    .upperLeftY (upperLeftY),
    .pointOut   (pointBus.source)
  );

  escapeEngine i_escapeEngine (
    .clk       (clk),
    .rstN      (rstN),
    .draw      (draw),
    .pointIn   (pointBus.sink),
    .resultOut (escapeBus.source)
  );

  colorMapper i_colorMapper (
    .clk        (clk),
    .rstN       (rstN),
    .draw       (draw),
    .pixelReady (pixelReady),
    .resultIn   (escapeBus.sink),
    .pixelValid (pixelValid),
    .pixelX     (pixelX),
    .pixelY     (pixelY),
    .pixelColor (pixelColor),
    .frameDone  (frameDone)
  );

endmodule

//--- verif/fractalModel.svh
/*
  Reference model of the screen walk, escape iteration and color rule.
  Works in the same signed 4.32 fixed point as the design; included
  inside the testbench module.
*/
`ifndef FRACTAL_MODEL_SVH
`define FRACTAL_MODEL_SVH

// Corner plus position times the zoomed step
function automatic fractalPkg::coordT modelCoord(fractalPkg::coordT corner,
    fractalPkg::coordT baseStep, fractalPkg::zoomT zoom, int pos);
  return corner + fractalPkg::coordT'(pos) * (baseStep >>> zoom);
endfunction

function automatic fractalPkg::iterT modelCount(fractalPkg::coordT cr, fractalPkg::coordT ci);
  logic signed [71:0] re;
  logic signed [71:0] im;
  logic signed [71:0] reSq;
  logic signed [71:0] imSq;
  fractalPkg::coordT  nextRe;
  fractalPkg::coordT  nextIm;
  re = '0;
  im = '0;
  for (int n = 0; n < fractalPkg::MAX_ITER; n++) begin
    reSq = (re * re) >>> 32;                             // Bits below 2^-32 dropped
    imSq = (im * im) >>> 32;
    if (reSq + imSq >= (72'(fractalPkg::ESCAPE_INT) <<< 32))
      return fractalPkg::iterT'(n);
    nextRe = fractalPkg::coordT'(reSq - imSq) + cr;
    nextIm = fractalPkg::coordT'((re * im) >>> 31) + ci; // 2*re*im
    re = 72'(nextRe);
    im = 72'(nextIm);
  end
  return fractalPkg::iterT'(fractalPkg::MAX_ITER);
endfunction

function automatic fractalPkg::colorT modelColor(fractalPkg::iterT n);
  if (n == fractalPkg::iterT'(fractalPkg::MAX_ITER))
    return '0;                                           // Inside the set
  return {n[5:0], 2'b11};
endfunction

`endif

//--- verif/fractalTb.sv
/*
  Testbench for fractalTop. Each table row draws a frame and checks the
  first pixels, or the whole frame, against the reference model.
  pixelReady follows an LCG; the run stops at the first error.
*/
`timescale 1ns/100ps

module fractalTb;

  `include "fractalModel.svh"

  typedef struct packed {
    fractalPkg::zoomT  zoom;
    fractalPkg::coordT cornerX;
    fractalPkg::coordT cornerY;
    logic [31:0]       pixCount;
    logic              runToEnd;
  } stimRowT;

  localparam int NUM_ROWS      = 5;
  localparam int FRAME_PIXELS  = fractalPkg::SCREEN_W * fractalPkg::SCREEN_H;
  localparam int PIXEL_TIMEOUT = 5000;   // Cycles allowed between two pixels

  logic clk;
  logic rstN;
  logic draw;
  logic pixelReady;
  logic pixelValid;
  logic frameDone;
  logic [31:0]       rngState;
  fractalPkg::zoomT  zoomLevel;
  fractalPkg::coordT upperLeftX;
  fractalPkg::coordT upperLeftY;
  fractalPkg::vgaXT  pixelX;
  fractalPkg::vgaYT  pixelY;
  fractalPkg::colorT pixelColor;

  stimRowT stimTable [NUM_ROWS] = '{
    '{5'd0, 36'hE00000000, 36'hF00000000, 32'd700, 1'b0},  // (-2, -1), edge counts
    '{5'd3, 36'hF40000000, 36'h020000000, 32'd500, 1'b0},  // (-0.75, 0.125)
    '{5'd7, 36'hFE0000000, 36'hFF0000000, 32'd300, 1'b0},  // Near origin, all inside
    '{5'd7, 36'hF40000000, 36'h01999999A, 32'd300, 1'b0},  // (-0.75, 0.1), cardioid edge
    '{5'd2, 36'h280000000, 36'h100000000, 32'(FRAME_PIXELS), 1'b1}  // Far outside
  };

  fractalTop i_fractalTop (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk) begin
    #1;
    rngState = lcgNext(rngState);
    pixelReady = rngState[28] | rngState[29];  // Ready about 3 cycles in 4
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic checkPos(input fractalPkg::vgaXT gotX, input fractalPkg::vgaYT gotY,
                          input fractalPkg::vgaXT expX, input fractalPkg::vgaYT expY);
    if (gotX !== expX || gotY !== expY)
      abortRun($sformatf("CHECK FAILED at %0t: pixel (%0d, %0d), expected (%0d, %0d)",
                         $time, gotX, gotY, expX, expY));
  endtask

  task automatic checkColor(input fractalPkg::colorT got, input fractalPkg::colorT exp);
    if (got !== exp)
      abortRun($sformatf("CHECK FAILED at %0t: color %0h at (%0d, %0d), expected %0h",
                         $time, got, pixelX, pixelY, exp));
  endtask

  task automatic checkDone(input logic exp);
    if (frameDone !== exp)
      abortRun($sformatf("CHECK FAILED at %0t: frameDone %b, expected %b",
                         $time, frameDone, exp));
  endtask

  task automatic pulseDraw(input stimRowT row);
    @(posedge clk);
    #1;
    zoomLevel  = row.zoom;
    upperLeftX = row.cornerX;
    upperLeftY = row.cornerY;
    draw       = 1'b1;
    @(posedge clk);
    #1;
    draw = 1'b0;
  endtask

  // Pixels are sampled at the falling edge, half a cycle from any change
  task automatic collectPixels(input stimRowT row);
    int done;
    int idle;
    logic heldValid;
    fractalPkg::vgaXT  heldX;
    fractalPkg::vgaYT  heldY;
    fractalPkg::colorT heldColor;
    fractalPkg::coordT cx;
    fractalPkg::coordT cy;
    done = 0;
    idle = 0;
    heldValid = 1'b0;
    while (done < int'(row.pixCount)) begin
      @(negedge clk);
      if (heldValid) begin
        if (!pixelValid)
          abortRun("Pixel was withdrawn while pixelReady was low");
        checkPos(pixelX, pixelY, heldX, heldY);
        checkColor(pixelColor, heldColor);
      end
      heldValid = pixelValid && !pixelReady;
      heldX     = pixelX;
      heldY     = pixelY;
      heldColor = pixelColor;
      if (pixelValid && pixelReady) begin
        cx = modelCoord(row.cornerX, fractalPkg::X_STEP, row.zoom, done % fractalPkg::SCREEN_W);
        cy = modelCoord(row.cornerY, fractalPkg::Y_STEP, row.zoom, done / fractalPkg::SCREEN_W);
        checkPos(pixelX, pixelY, fractalPkg::vgaXT'(done % fractalPkg::SCREEN_W),
                 fractalPkg::vgaYT'(done / fractalPkg::SCREEN_W));
        checkColor(pixelColor, modelColor(modelCount(cx, cy)));
        done++;
        idle = 0;
      end else begin
        idle++;
        if (idle > PIXEL_TIMEOUT)
          abortRun($sformatf("Timeout: no pixel for %0d cycles after %0d pixels",
                             PIXEL_TIMEOUT, done));
      end
    end
  endtask

  // Last pixel leaves on the next edge; nothing may follow it
  task automatic finishFrame;
    @(posedge clk);
    #1;
    checkDone(1'b1);
    repeat (200) begin
      @(negedge clk);
      if (pixelValid)
        abortRun("An extra pixel came out after the end of the frame");
    end
  endtask

  initial begin
    rngState   = 32'ha7;
    rstN       = 1'b0;
    draw       = 1'b0;
    pixelReady = 1'b0;
    zoomLevel  = '0;
    upperLeftX = '0;
    upperLeftY = '0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    checkDone(1'b0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      pulseDraw(stimTable[r]);                 // Cuts short the previous row's frame
      checkDone(1'b0);
      collectPixels(stimTable[r]);
      if (stimTable[r].runToEnd)
        finishFrame();
    end
    pulseDraw(stimTable[0]);
    checkDone(1'b0);                           // Cleared by the new draw
    $display("** PASS **");
    $finish;
  end

endmodule

//--- project.f
+incdir+verif
verilog/fractalPkg.sv
verilog/fractalIfs.sv
verilog/coordGenerator.sv
verilog/escapeEngine.sv
verilog/colorMapper.sv
verilog/fractalTop.sv
verif/fractalTb.sv

//--- Makefile
# Verilator build and run of the Mandelbrot pipeline testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fractalTb \
		-f project.f -Mdir obj_dir
	./obj_dir/VfractalTb

clean:
	rm -rf obj_dir

.PHONY: sim clean
